/* source/cpu_types_pkg.sv */
package cpu_types_pkg;

	// ==============================
	// Data widths
	// ==============================

	// One machine word.
	typedef logic [31:0] word_t;

	// HI in [63:32], LO in [31:0].
	typedef logic [63:0] dword_t;

	// ==============================
	// Addresses and lanes
	// ==============================

	typedef logic [31:0] inst_addr_t;  // Fetch side pc.
	typedef logic [31:0] mem_addr_t;   // Data side byte address.

	// One enable per byte lane.
	typedef logic [3:0] byte_sel_t;

	// ==============================
	// Flags
	// ==============================

	typedef logic bit_t;

endpackage

/* source/cpu_oper_pkg.sv */
package cpu_oper_pkg;

	// ==============================
	// Decoded operation
	// ==============================

	typedef logic [3:0] oper_t;

	localparam oper_t OP_NOP   = 4'd0;

	// Result producing ops.
	localparam oper_t OP_ORI   = 4'd1;
	localparam oper_t OP_JAL   = 4'd2;
	localparam oper_t OP_MFHI  = 4'd3;
	localparam oper_t OP_MFLO  = 4'd4;

	// HI/LO writers.
	localparam oper_t OP_MTHI  = 4'd5;
	localparam oper_t OP_MTLO  = 4'd6;
	localparam oper_t OP_MADDU = 4'd7;  // Multi-cycle op that stalls EX.

	// ==============================
	// Memory access
	// ==============================

	localparam oper_t OP_LW    = 4'd8;
	localparam oper_t OP_SW    = 4'd9;

	// Codes 10 to 15 decode as no-ops in EX.

endpackage

/* source/ex_multi_cyc.sv */
`timescale 1ns/1ps

module ex_multi_cyc #(
	parameter int MADDU_CYCLES = 2
) (
	input  logic                  clk,
	input  logic                  rst,
	input  cpu_oper_pkg::oper_t   op,
	input  cpu_types_pkg::dword_t mul_u,
	input  cpu_types_pkg::dword_t hilo,
	output cpu_types_pkg::dword_t ret,
	output cpu_types_pkg::bit_t   is_busy
);

	import cpu_types_pkg::*;
	import cpu_oper_pkg::*;

	localparam int CNT_W = (MADDU_CYCLES > 1) ? $clog2(MADDU_CYCLES) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST =
		CNT_W'((MADDU_CYCLES > 1) ? MADDU_CYCLES - 2 : 0);

	typedef enum logic [1:0] {
		IDLE,
		WORK,
		DONE
	} state_t;

	state_t           state;
	logic [CNT_W-1:0] cnt;
	bit_t             start;

	dword_t prod_q;  // Captured reg1 * reg2.
	dword_t acc_q;   // Captured HI/LO.
	dword_t sum_q;
	dword_t done_sum;

	assign start = !rst && (state == IDLE) && (op == OP_MADDU);

	// Busy from first sight of the op through the last WORK cycle.
	assign is_busy = start || (state == WORK);

	// ==============================
	// Control
	// ==============================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= IDLE;
			cnt   <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (start)
					begin
						cnt   <= '0;
						state <= (MADDU_CYCLES > 1) ? WORK : DONE;
					end
				end
				WORK:
				begin
					if (cnt == CNT_LAST)
						state <= DONE;
					else
						cnt <= cnt + 1'b1;
				end
				default: state <= IDLE;  // Result leaves DONE at this edge.
			endcase
		end
	end

	// ==============================
	// Datapath
	// ==============================

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			prod_q <= mul_u;
			acc_q  <= hilo;
		end
		if (state == WORK)
			sum_q <= prod_q + acc_q;  // Wraps mod 2^64.
	end

	// Single-cycle setting has no WORK pass.
	assign done_sum = (MADDU_CYCLES > 1) ? sum_q : prod_q + acc_q;
	assign ret      = (state == DONE) ? done_sum : '0;

endmodule

/* source/cpu_ex.sv */
`timescale 1ns/1ps

module cpu_ex #(
	parameter int MADDU_CYCLES = 2
) (
	input  logic                      clk,
	input  logic                      rst,
	input  cpu_oper_pkg::oper_t       op,
	input  cpu_types_pkg::inst_addr_t pc,
	input  cpu_types_pkg::word_t      reg1,
	input  cpu_types_pkg::word_t      reg2,
	input  cpu_types_pkg::word_t      imm,
	input  cpu_types_pkg::dword_t     hilo_unsafe,
	input  cpu_types_pkg::bit_t       mem_hilo_we,
	input  cpu_types_pkg::dword_t     mem_hilo_wdata,
	output cpu_types_pkg::bit_t       hilo_we,
	output cpu_types_pkg::dword_t     hilo_wdata,
	output cpu_types_pkg::bit_t       memory_ce,
	output cpu_types_pkg::bit_t       memory_we,
	output cpu_types_pkg::mem_addr_t  memory_addr,
	output cpu_types_pkg::word_t      memory_wdata,
	output cpu_types_pkg::byte_sel_t  memory_sel,
	output cpu_types_pkg::word_t      ret,
	output cpu_types_pkg::bit_t       stall_req
);

	import cpu_types_pkg::*;
	import cpu_oper_pkg::*;

	// ==============================
	// HI/LO source select
	// ==============================

	dword_t hilo_safe;
	word_t  hi;
	word_t  lo;

	always_comb
	begin
		if (rst)
			hilo_safe = '0;
		else if (mem_hilo_we)
			hilo_safe = mem_hilo_wdata;  // Write still sitting in MEM.
		else
			hilo_safe = hilo_unsafe;
	end

	assign {hi, lo} = hilo_safe;

	// ==============================
	// Memory request
	// ==============================

	bit_t is_load;
	bit_t is_store;

	assign is_load      = (op == OP_LW);
	assign is_store     = (op == OP_SW);
	assign memory_ce    = is_load | is_store;
	assign memory_we    = is_store;
	assign memory_addr  = reg1 + imm;
	assign memory_wdata = reg2;
	assign memory_sel   = memory_ce ? 4'b1111 : 4'b0000;  // Word access only.

	// ==============================
	// Multiply-accumulate
	// ==============================

	dword_t mul_u;
	dword_t multi_cyc_ret;
	bit_t   we_hilo;

	assign mul_u = dword_t'(reg1) * dword_t'(reg2);

	ex_multi_cyc #(
		.MADDU_CYCLES(MADDU_CYCLES)
	) multi_cyc_instance (
		.clk    (clk),
		.rst    (rst),
		.op     (op),
		.mul_u  (mul_u),
		.hilo   (hilo_safe),
		.ret    (multi_cyc_ret),
		.is_busy(stall_req)
	);

	assign we_hilo = (op == OP_MTHI) || (op == OP_MTLO) || (op == OP_MADDU);

	// MADDU only writes in its DONE cycle.
	assign hilo_we = we_hilo & ~stall_req;

	// ==============================
	// Result and HI/LO data
	// ==============================

	always_comb
	begin
		ret        = '0;
		hilo_wdata = hilo_safe;
		case (op)
			OP_ORI:   ret = reg1 | imm;
			OP_JAL:   ret = pc + 32'd8;  // Return past the delay slot.
			OP_MFHI:  ret = hi;
			OP_MFLO:  ret = lo;
			OP_MTHI:  hilo_wdata = {reg1, lo};
			OP_MTLO:  hilo_wdata = {hi, reg1};
			OP_MADDU: hilo_wdata = multi_cyc_ret;
			default:  ret = '0;
		endcase
	end

endmodule

/* source/cpu_ex_mem.sv */
`timescale 1ns/1ps

module cpu_ex_mem (
	input  logic                     clk,
	input  logic                     rst,
	input  cpu_types_pkg::bit_t      stall,
	input  cpu_types_pkg::word_t     ret,
	input  cpu_types_pkg::bit_t      memory_ce,
	input  cpu_types_pkg::bit_t      memory_we,
	input  cpu_types_pkg::mem_addr_t memory_addr,
	input  cpu_types_pkg::word_t     memory_wdata,
	input  cpu_types_pkg::byte_sel_t memory_sel,
	input  cpu_types_pkg::bit_t      hilo_we,
	input  cpu_types_pkg::dword_t    hilo_wdata,
	output cpu_types_pkg::word_t     mem_ret,
	output cpu_types_pkg::bit_t      mem_ce,
	output cpu_types_pkg::bit_t      mem_we,
	output cpu_types_pkg::mem_addr_t mem_addr,
	output cpu_types_pkg::word_t     mem_wdata,
	output cpu_types_pkg::byte_sel_t mem_sel,
	output cpu_types_pkg::bit_t      mem_hilo_we,
	output cpu_types_pkg::dword_t    mem_hilo_wdata
);

	// ==============================
	// EX/MEM register
	// ==============================

	always_ff @(posedge clk)
	begin
		if (rst || stall)
		begin
			// Bubble while EX is busy.
			mem_ret        <= '0;
			mem_ce         <= 1'b0;
			mem_we         <= 1'b0;
			mem_addr       <= '0;
			mem_wdata      <= '0;
			mem_sel        <= '0;
			mem_hilo_we    <= 1'b0;
			mem_hilo_wdata <= '0;
		end
		else
		begin
			mem_ret        <= ret;
			mem_ce         <= memory_ce;
			mem_we         <= memory_we;
			mem_addr       <= memory_addr;
			mem_wdata      <= memory_wdata;
			mem_sel        <= memory_sel;
			mem_hilo_we    <= hilo_we;  // Also feeds the EX forward path.
			mem_hilo_wdata <= hilo_wdata;
		end
	end

endmodule

/* source/cpu_hilo.sv */
`timescale 1ns/1ps

module cpu_hilo (
	input  logic                  clk,
	input  logic                  rst,
	input  cpu_types_pkg::bit_t   we,
	input  cpu_types_pkg::dword_t wdata,
	output cpu_types_pkg::dword_t hilo
);

	// ==============================
	// Architectural HI/LO
	// ==============================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			hilo <= '0;
		end
		else if (we)
		begin
			// Commit from MEM.
			hilo <= wdata;
		end
	end

endmodule

/* source/cpu_ex_top.sv */
`timescale 1ns/1ps

module cpu_ex_top #(
	parameter int MADDU_CYCLES = 2
) (
	input  logic                      clk,
	input  logic                      rst,
	input  cpu_oper_pkg::oper_t       op,
	input  cpu_types_pkg::inst_addr_t pc,
	input  cpu_types_pkg::word_t      reg1,
	input  cpu_types_pkg::word_t      reg2,
	input  cpu_types_pkg::word_t      imm,
	output cpu_types_pkg::bit_t       stall,
	output cpu_types_pkg::bit_t       mem_ce,
	output cpu_types_pkg::bit_t       mem_we,
	output cpu_types_pkg::mem_addr_t  mem_addr,
	output cpu_types_pkg::word_t      mem_wdata,
	output cpu_types_pkg::byte_sel_t  mem_sel,
	output cpu_types_pkg::word_t      mem_ret,
	output cpu_types_pkg::dword_t     hilo
);

	import cpu_types_pkg::*;

	// EX outputs.
	word_t     ex_ret;
	bit_t      ex_ce;
	bit_t      ex_we;
	mem_addr_t ex_addr;
	word_t     ex_wdata;
	byte_sel_t ex_sel;
	bit_t      ex_hilo_we;
	dword_t    ex_hilo_wdata;

	// MEM stage HI/LO write, to forward and commit.
	bit_t      mem_hilo_we;
	dword_t    mem_hilo_wdata;

	// ==============================
	// Stages
	// ==============================

	cpu_ex #(
		.MADDU_CYCLES(MADDU_CYCLES)
	) ex_instance (
		.clk           (clk),
		.rst           (rst),
		.op            (op),
		.pc            (pc),
		.reg1          (reg1),
		.reg2          (reg2),
		.imm           (imm),
		.hilo_unsafe   (hilo),
		.mem_hilo_we   (mem_hilo_we),
		.mem_hilo_wdata(mem_hilo_wdata),
		.hilo_we       (ex_hilo_we),
		.hilo_wdata    (ex_hilo_wdata),
		.memory_ce     (ex_ce),
		.memory_we     (ex_we),
		.memory_addr   (ex_addr),
		.memory_wdata  (ex_wdata),
		.memory_sel    (ex_sel),
		.ret           (ex_ret),
		.stall_req     (stall)
	);

	cpu_ex_mem ex_mem_instance (
		.clk           (clk),
		.rst           (rst),
		.stall         (stall),
		.ret           (ex_ret),
		.memory_ce     (ex_ce),
		.memory_we     (ex_we),
		.memory_addr   (ex_addr),
		.memory_wdata  (ex_wdata),
		.memory_sel    (ex_sel),
		.hilo_we       (ex_hilo_we),
		.hilo_wdata    (ex_hilo_wdata),
		.mem_ret       (mem_ret),
		.mem_ce        (mem_ce),
		.mem_we        (mem_we),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.mem_sel       (mem_sel),
		.mem_hilo_we   (mem_hilo_we),
		.mem_hilo_wdata(mem_hilo_wdata)
	);

	cpu_hilo hilo_instance (
		.clk  (clk),
		.rst  (rst),
		.we   (mem_hilo_we),
		.wdata(mem_hilo_wdata),
		.hilo (hilo)
	);

endmodule

/* testbench/tb_cpu_ex_top.sv */
`timescale 1ns/1ps

module tb_cpu_ex_top;

	import cpu_types_pkg::*;
	import cpu_oper_pkg::*;

	localparam int MADDU_CYCLES = 2;
	localparam int N_INSTR      = 400;
	localparam int CLK_NS       = 40;
	localparam int TIMEOUT_NS   = (N_INSTR * (MADDU_CYCLES + 1) + 50) * CLK_NS;

	logic       clk;
	logic       rst;
	oper_t      op;
	inst_addr_t pc;
	word_t      reg1;
	word_t      reg2;
	word_t      imm;
	bit_t       stall;
	bit_t       mem_ce;
	bit_t       mem_we;
	mem_addr_t  mem_addr;
	word_t      mem_wdata;
	byte_sel_t  mem_sel;
	word_t      mem_ret;
	dword_t     hilo;

	integer seed;
	int     accepted;
	int     stall_run;  // Stalled edges for the op now on the inputs.
	oper_t  last_op;

	// Model state and expected EX/MEM contents.
	dword_t    model_hilo;
	dword_t    exp_hilo;
	dword_t    exp_hilo_wdata;
	bit_t      exp_hilo_we;
	bit_t      exp_bubble;
	bit_t      exp_ce;
	bit_t      exp_we;
	word_t     exp_ret;
	word_t     exp_wdata;
	mem_addr_t exp_addr;
	byte_sel_t exp_sel;

	oper_t op_table[10] = '{OP_NOP, OP_ORI, OP_JAL, OP_MFHI, OP_MFLO,
		OP_MTHI, OP_MTLO, OP_MADDU, OP_LW, OP_SW};
	oper_t hilo_readers[3] = '{OP_MFHI, OP_MFLO, OP_MADDU};

	cpu_ex_top #(
		.MADDU_CYCLES(MADDU_CYCLES)
	) dut (
		.clk      (clk),
		.rst      (rst),
		.op       (op),
		.pc       (pc),
		.reg1     (reg1),
		.reg2     (reg2),
		.imm      (imm),
		.stall    (stall),
		.mem_ce   (mem_ce),
		.mem_we   (mem_we),
		.mem_addr (mem_addr),
		.mem_wdata(mem_wdata),
		.mem_sel  (mem_sel),
		.mem_ret  (mem_ret),
		.hilo     (hilo)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("Run timed out before all instructions were accepted.");
		$display("TEST RESULT: FAIL");
		$fatal(1, "Watchdog expired.");
	end

	// ==============================
	// Compare tasks
	// ==============================

	task automatic fail_mismatch(input string name, input logic [63:0] exp,
		input logic [63:0] act);
	begin
		$display("MISMATCH at %0t: %s expected %0h, got %0h", $time, name, exp, act);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Stopped on first mismatch.");
	end
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
	begin
		if (act !== exp)
			fail_mismatch(name, exp, act);
	end
	endtask

	task automatic check_dword(input string name, input dword_t exp, input dword_t act);
	begin
		if (act !== exp)
			fail_mismatch(name, exp, act);
	end
	endtask

	task automatic check_sel(input string name, input byte_sel_t exp, input byte_sel_t act);
	begin
		if (act !== exp)
			fail_mismatch(name, exp, act);
	end
	endtask

	task automatic check_bit(input string name, input bit_t exp, input bit_t act);
	begin
		if (act !== exp)
			fail_mismatch(name, exp, act);
	end
	endtask

	task automatic check_addr(input string name, input mem_addr_t exp, input mem_addr_t act);
	begin
		if (act !== exp)
			fail_mismatch(name, exp, act);
	end
	endtask

	// ==============================
	// Stimulus and model
	// ==============================

	task automatic draw_instruction();
		logic [31:0] r;
		oper_t       next_op;
	begin
		r = $random(seed);
		if ((last_op == OP_MTHI || last_op == OP_MTLO) && r[31])
			next_op = hilo_readers[r[15:0] % 3];  // Exercise the forward path.
		else
			next_op = op_table[r[15:0] % 10];
		op      <= next_op;
		pc      <= $random(seed);
		reg1    <= $random(seed);
		reg2    <= $random(seed);
		imm     <= $random(seed);
		last_op = next_op;
	end
	endtask

	task automatic load_bubble();
	begin
		exp_bubble  = 1'b1;
		exp_ret     = '0;
		exp_ce      = 1'b0;
		exp_we      = 1'b0;
		exp_addr    = '0;
		exp_wdata   = '0;
		exp_sel     = '0;
		exp_hilo_we = 1'b0;
	end
	endtask

	task automatic model_accept();
	begin
		load_bubble();
		exp_bubble = 1'b0;
		case (op)
			OP_ORI:  exp_ret = reg1 | imm;
			OP_JAL:  exp_ret = pc + 32'd8;
			OP_MFHI: exp_ret = model_hilo[63:32];
			OP_MFLO: exp_ret = model_hilo[31:0];
			OP_MTHI:
			begin
				model_hilo[63:32] = reg1;
				exp_hilo_we = 1'b1;
			end
			OP_MTLO:
			begin
				model_hilo[31:0] = reg1;
				exp_hilo_we = 1'b1;
			end
			OP_MADDU:
			begin
				model_hilo = model_hilo + {32'd0, reg1} * {32'd0, reg2};  // Mod 2^64.
				exp_hilo_we = 1'b1;
			end
			OP_LW, OP_SW:
			begin
				exp_ce    = 1'b1;
				exp_we    = (op == OP_SW);
				exp_addr  = reg1 + imm;
				exp_wdata = reg2;
				exp_sel   = 4'b1111;
			end
			default: ;
		endcase
		exp_hilo_wdata = model_hilo;
	end
	endtask

	task automatic check_outputs();
	begin
		check_bit("stall", (op == OP_MADDU) && (stall_run < MADDU_CYCLES), stall);
		check_word("mem_ret", exp_ret, mem_ret);
		check_bit("mem_ce", exp_ce, mem_ce);
		check_bit("mem_we", exp_we, mem_we);
		if (exp_ce || exp_bubble)
		begin
			check_addr("mem_addr", exp_addr, mem_addr);
			check_sel("mem_sel", exp_sel, mem_sel);
		end
		if (exp_we || exp_bubble)
			check_word("mem_wdata", exp_wdata, mem_wdata);
		check_dword("hilo", exp_hilo, hilo);
	end
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial
	begin
		seed       = 76;
		rst        = 1'b1;
		op         = OP_NOP;
		pc         = '0;
		reg1       = '0;
		reg2       = '0;
		imm        = '0;
		last_op    = OP_NOP;
		model_hilo = '0;
		exp_hilo   = '0;
		stall_run  = 0;
		accepted   = 0;
		load_bubble();

		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_outputs();  // Cleared state after reset.

		while (accepted < N_INSTR)
		begin
			@(posedge clk);
			if (exp_hilo_we)
				exp_hilo = exp_hilo_wdata;  // MEM write commits this edge.
			if (!stall)
			begin
				model_accept();
				stall_run = 0;
				accepted++;
				draw_instruction();
			end
			else
			begin
				load_bubble();
				stall_run++;
			end
			@(negedge clk);
			check_outputs();
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* flist.f */
source/cpu_types_pkg.sv
source/cpu_oper_pkg.sv
source/ex_multi_cyc.sv
source/cpu_ex.sv
source/cpu_ex_mem.sv
source/cpu_hilo.sv
source/cpu_ex_top.sv
testbench/tb_cpu_ex_top.sv

/* Bender.yml */
package:
  name: cpu_ex_top

sources:
  # Packages first, then the RTL in dependency order.
  - files:
      - source/cpu_types_pkg.sv
      - source/cpu_oper_pkg.sv
      - source/ex_multi_cyc.sv
      - source/cpu_ex.sv
      - source/cpu_ex_mem.sv
      - source/cpu_hilo.sv
      - source/cpu_ex_top.sv

  - target: test
    files:
      - testbench/tb_cpu_ex_top.sv
